// File: src.f
source/mpram_pkg.sv
source/multi_read_ram.sv
source/xor_write_encoder.sv
source/xor_read_decoder.sv
source/xor_mpram.sv
dv/mpram_chk.sv
dv/mpram_tb.sv

// File: run.sh
#!/bin/sh
# build the XOR multi-port RAM testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module mpram_tb -f src.f -o mpram_sim \
  && ./obj_dir/mpram_sim | tee /dev/stderr | grep -qF '>>> PASS' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: dv/mpram_tb.sv
/*
  testbench of the XOR multi-port RAM
  clock and reset, directed and random stimulus, shadow reference model,
  output comparison and watchdog
*/
module mpram_tb import mpram_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_WR        = 3;
  localparam int NUM_RD        = 2;
  localparam int CLK_PERIOD    = 8;
  localparam int RST_CYCLES    = 8;
  localparam int FILL_ROUNDS   = 4;
  localparam int HOT_RANGE     = 16;
  localparam int RANDOM_CYCLES = 800;
  localparam logic [31:0] LCG_SEED = 32'hf8510460;

  // zero scan, fill with readback, forwarding and same-cycle sections
  localparam int DIRECTED_CYCLES = DEPTH / NUM_RD + FILL_ROUNDS * (1 + NUM_WR) + 4 * NUM_WR;
  localparam int WATCHDOG_CYCLES = RST_CYCLES + DEPTH + DIRECTED_CYCLES + RANDOM_CYCLES + 100;

  logic                 clk_w = 1'b0;
  logic                 a_rst_n;
  logic    [NUM_WR-1:0] wr_valid;
  wr_req_t [NUM_WR-1:0] wr_req;
  logic                 wr_ready;
  logic    [NUM_RD-1:0] rd_valid;
  rd_req_t [NUM_RD-1:0] rd_req;
  logic                 rd_ready;
  word_t   [NUM_RD-1:0] rd_data;
  logic    [NUM_RD-1:0] rd_data_valid;

  // reference state, owned by the compare process
  word_t             shadow [DEPTH];
  logic [NUM_RD-1:0] exp_valid = '0;
  word_t             exp_data [NUM_RD];
  int                reads_checked = 0;
  logic [31:0]       lcg_state = LCG_SEED;

  always #(CLK_PERIOD / 2) clk_w = ~clk_w;

  xor_mpram #(
    .NUM_WR (NUM_WR),
    .NUM_RD (NUM_RD)
  ) DUT (
    .clk_w           (clk_w),
    .a_rst_n         (a_rst_n),
    .wr_valid_i      (wr_valid),
    .wr_req_i        (wr_req),
    .wr_ready_o      (wr_ready),
    .rd_valid_i      (rd_valid),
    .rd_req_i        (rd_req),
    .rd_ready_o      (rd_ready),
    .rd_data_o       (rd_data),
    .rd_data_valid_o (rd_data_valid)
  );

  // ==================================================
  // helpers
  // ==================================================

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected word of a read, shadow as it stood before this edge's writes
  function automatic word_t ref_read(addr_t addr);
    return shadow[addr];
  endfunction

  task automatic report_error(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic clear_inputs();
    wr_valid <= '0;
    wr_req   <= '0;
    rd_valid <= '0;
    rd_req   <= '0;
  endtask

  task automatic set_write(int port, addr_t addr, word_t data);
    wr_valid[port]      <= 1'b1;
    wr_req[port].addr <= addr;
    wr_req[port].data <= data;
  endtask

  task automatic set_read(int port, addr_t addr);
    rd_valid[port]      <= 1'b1;
    rd_req[port].addr <= addr;
  endtask

  // later NBAs of the same edge override the idle values
  task automatic next_cycle();
    @(posedge clk_w);
    clear_inputs();
  endtask

  task automatic wait_for_ready();
    int cycles;
    cycles = 0;
    @(negedge clk_w);
    while (!(wr_ready === 1'b1 && rd_ready === 1'b1)) begin
      assert (wr_ready === rd_ready) else
        report_error("wr_ready_o and rd_ready_o differ during the init sweep");
      cycles++;
      if (cycles > DEPTH + 16) begin
        report_error("ready did not rise after the init sweep");
      end
      @(negedge clk_w);
    end
    assert (cycles >= DEPTH) else
      report_error($sformatf("ready rose after %0d cycles, before the sweep ended", cycles));
  endtask

  // write ports never share an address within one cycle
  task automatic drive_random_cycle();
    logic [31:0]       r;
    addr_t             addr;
    addr_t             used [NUM_WR];
    logic [NUM_WR-1:0] taken;
    logic              clash;
    taken = '0;
    for (int k = 0; k < NUM_WR; k++) begin
      r     = next_rand();
      addr  = addr_t'((r >> 8) % HOT_RANGE);
      clash = 1'b0;
      for (int j = 0; j < k; j++) begin
        if (taken[j] && used[j] == addr) begin
          clash = 1'b1;
        end
      end
      if (r[29] && !clash) begin
        taken[k] = 1'b1;
        used[k]  = addr;
        set_write(k, addr, next_rand());
      end
    end
    for (int p = 0; p < NUM_RD; p++) begin
      r = next_rand();
      if (r[30]) begin
        set_read(p, addr_t'((r >> 8) % HOT_RANGE));
      end
    end
  endtask

  // ==================================================
  // reference update and output comparison
  // ==================================================

  always @(negedge clk_w) begin
    for (int p = 0; p < NUM_RD; p++) begin
      assert (rd_data_valid[p] === exp_valid[p]) else
        report_error($sformatf("FAILED at %0t: rd_data_valid_o[%0d] is %b, expected %b",
                               $time, p, rd_data_valid[p], exp_valid[p]));
      if (exp_valid[p]) begin
        assert (rd_data[p] === exp_data[p]) else
          report_error($sformatf("FAILED at %0t: rd_data_o[%0d] is %h, expected %h",
                                 $time, p, rd_data[p], exp_data[p]));
        reads_checked++;
      end
    end
    // the init sweep leaves every word at zero
    if (!a_rst_n) begin
      exp_valid = '0;
      for (int a = 0; a < DEPTH; a++) begin
        shadow[a] = '0;
      end
    end else begin
      for (int p = 0; p < NUM_RD; p++) begin
        exp_valid[p] = rd_valid[p] && rd_ready;
        if (exp_valid[p]) begin
          exp_data[p] = ref_read(rd_req[p].addr);
        end
      end
      for (int k = 0; k < NUM_WR; k++) begin
        if (wr_valid[k] && wr_ready) begin
          shadow[wr_req[k].addr] = wr_req[k].data;
        end
      end
    end
  end

  // ==================================================
  // stimulus
  // ==================================================

  initial begin
    a_rst_n <= 1'b0;
    clear_inputs();
    repeat (RST_CYCLES) begin
      @(negedge clk_w);
      assert (wr_ready === 1'b0 && rd_ready === 1'b0) else
        report_error("ready was high while reset was asserted");
    end
    @(posedge clk_w);
    a_rst_n <= 1'b1;
    wait_for_ready();

    // every word reads zero after the sweep
    for (int a = 0; a < DEPTH; a += NUM_RD) begin
      next_cycle();
      for (int p = 0; p < NUM_RD; p++) begin
        set_read(p, addr_t'(a + p));
      end
    end

    // all write ports at once, then readback from every read port
    for (int r = 0; r < FILL_ROUNDS; r++) begin
      next_cycle();
      for (int k = 0; k < NUM_WR; k++) begin
        set_write(k, addr_t'(r * NUM_WR + k), word_t'(32'h5a00_0000 + (k << 16) + r * 257));
      end
    end
    for (int a = 0; a < FILL_ROUNDS * NUM_WR; a++) begin
      next_cycle();
      for (int p = 0; p < NUM_RD; p++) begin
        set_read(p, addr_t'(a));
      end
    end

    // read one cycle after the write, served by forwarding
    for (int k = 0; k < NUM_WR; k++) begin
      next_cycle();
      set_write(k, addr_t'(40 + k), word_t'(32'h3c3c_0000 + k));
      next_cycle();
      for (int p = 0; p < NUM_RD; p++) begin
        set_read(p, addr_t'(40 + k));
      end
    end

    // read in the write cycle gets the old word, the next cycle the new one
    for (int k = 0; k < NUM_WR; k++) begin
      next_cycle();
      set_write(k, addr_t'(k), word_t'(32'hc0de_0000 + k));
      set_read(0, addr_t'(k));
      set_read(NUM_RD - 1, addr_t'(k));
      next_cycle();
      set_read(0, addr_t'(k));
    end

    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      next_cycle();
      drive_random_cycle();
    end
    repeat (3) next_cycle();

    if (reads_checked > 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      report_error("no read result was checked");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_error($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

// File: dv/mpram_chk.sv
/*
  bound assertions on the XOR multi-port RAM
  write address conflicts, sticky ready and read valid latency
*/
module mpram_chk import mpram_pkg::*; #(
  parameter int NUM_WR = 3,
  parameter int NUM_RD = 2
) (
  input logic                 clk_w,
  input logic                 a_rst_n,
  input logic    [NUM_WR-1:0] wr_valid_i,
  input wr_req_t [NUM_WR-1:0] wr_req_i,
  input logic                 wr_ready_i,
  input logic    [NUM_RD-1:0] rd_valid_i,
  input logic                 rd_ready_i,
  input logic    [NUM_RD-1:0] rd_data_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic              wr_clash;
  logic [NUM_RD-1:0] rd_fire;

  assign rd_fire = rd_valid_i & {NUM_RD{rd_ready_i}};

  // any pair of firing write ports on one address
  always_comb begin
    wr_clash = 1'b0;
    for (int a = 0; a < NUM_WR; a++) begin
      for (int b = a + 1; b < NUM_WR; b++) begin
        if (wr_ready_i && wr_valid_i[a] && wr_valid_i[b] &&
            wr_req_i[a].addr == wr_req_i[b].addr) begin
          wr_clash = 1'b1;
        end
      end
    end
  end

  // ==================================================
  // assertions
  // ==================================================

  no_write_clash: assert property (@(posedge clk_w) disable iff (!a_rst_n) !wr_clash)
    else $error("two write ports fired on one address in the same cycle");

  wr_ready_stays_high: assert property (
    @(posedge clk_w) disable iff (!a_rst_n) wr_ready_i |=> wr_ready_i)
    else $error("wr_ready_o dropped after it had risen");

  rd_ready_stays_high: assert property (
    @(posedge clk_w) disable iff (!a_rst_n) rd_ready_i |=> rd_ready_i)
    else $error("rd_ready_o dropped after it had risen");

  rd_valid_one_cycle: assert property (
    @(posedge clk_w) disable iff (!a_rst_n) rd_data_valid_i == $past(rd_fire))
    else $error("rd_data_valid_o does not follow the read fire by one cycle");

endmodule

bind xor_mpram mpram_chk #(
  .NUM_WR (NUM_WR),
  .NUM_RD (NUM_RD)
) u_chk (
  .clk_w           (clk_w),
  .a_rst_n         (a_rst_n),
  .wr_valid_i      (wr_valid_i),
  .wr_req_i        (wr_req_i),
  .wr_ready_i      (wr_ready_o),
  .rd_valid_i      (rd_valid_i),
  .rd_ready_i      (rd_ready_o),
  .rd_data_valid_i (rd_data_valid_o)
);

// File: source/xor_mpram.sv
/*
  top level of the XOR based multi-port RAM
  request handshakes, write encoder, read decoder and the two column arrays
*/
module xor_mpram import mpram_pkg::*; #(
  parameter int NUM_WR = 3,
  parameter int NUM_RD = 2
) (
  input  logic                  clk_w,
  input  logic                  a_rst_n,
  // write channel
  input  logic    [NUM_WR-1:0]  wr_valid_i,
  input  wr_req_t [NUM_WR-1:0]  wr_req_i,
  output logic                  wr_ready_o,
  // read channel
  input  logic    [NUM_RD-1:0]  rd_valid_i,
  input  rd_req_t [NUM_RD-1:0]  rd_req_i,
  output logic                  rd_ready_o,
  // read return, fixed one cycle latency
  output word_t   [NUM_RD-1:0]  rd_data_o,
  output logic    [NUM_RD-1:0]  rd_data_valid_o
);

  logic init_done;

  logic  [NUM_WR-1:0] wr_fire;
  logic  [NUM_RD-1:0] rd_fire;
  addr_t [NUM_RD-1:0] rd_addr;

  // write-port columns, NUM_WR-1 read slots per row
  addr_t [NUM_WR-1:0][NUM_WR-2:0] wcol_raddr;
  word_t [NUM_WR-1:0][NUM_WR-2:0] wcol_rdata;

  // read-port columns, one read slot per read port
  word_t [NUM_WR-1:0][NUM_RD-1:0] rcol_rdata;

  // shared write side of both columns of a row
  logic  [NUM_WR-1:0] col_we;
  addr_t [NUM_WR-1:0] col_waddr;
  word_t [NUM_WR-1:0] col_wdata;

  logic  [NUM_WR-1:0] pend_valid;
  addr_t [NUM_WR-1:0] pend_addr;
  word_t [NUM_WR-1:0] pend_data;

  // ==================================================
  // handshakes
  // ==================================================

  // ready is low only during the init sweep
  assign wr_ready_o = init_done;
  assign rd_ready_o = init_done;

  assign wr_fire = wr_valid_i & {NUM_WR{init_done}};
  assign rd_fire = rd_valid_i & {NUM_RD{init_done}};

  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      rd_addr[p] = rd_req_i[p].addr;
    end
  end

  // ==================================================
  // encoder and decoder
  // ==================================================

  xor_write_encoder #(
    .NUM_WR (NUM_WR)
  ) u_encoder (
    .clk_w        (clk_w),
    .a_rst_n      (a_rst_n),
    .wr_fire_i    (wr_fire),
    .wr_req_i     (wr_req_i),
    .col_rdata_i  (wcol_rdata),
    .col_raddr_o  (wcol_raddr),
    .col_we_o     (col_we),
    .col_waddr_o  (col_waddr),
    .col_wdata_o  (col_wdata),
    .pend_valid_o (pend_valid),
    .pend_addr_o  (pend_addr),
    .pend_data_o  (pend_data),
    .init_done_o  (init_done)
  );

  xor_read_decoder #(
    .NUM_WR (NUM_WR),
    .NUM_RD (NUM_RD)
  ) u_decoder (
    .clk_w           (clk_w),
    .a_rst_n         (a_rst_n),
    .rd_fire_i       (rd_fire),
    .rd_req_i        (rd_req_i),
    .col_rdata_i     (rcol_rdata),
    .pend_valid_i    (pend_valid),
    .pend_addr_i     (pend_addr),
    .pend_data_i     (pend_data),
    .rd_data_o       (rd_data_o),
    .rd_data_valid_o (rd_data_valid_o)
  );

  // ==================================================
  // column arrays, one row per write port
  // ==================================================

  for (genvar r = 0; r < NUM_WR; r++) begin : g_row
    multi_read_ram #(
      .NUM_PORTS (NUM_WR - 1)
    ) u_wr_col (
      .clk_w   (clk_w),
      .we_i    (col_we[r]),
      .waddr_i (col_waddr[r]),
      .wdata_i (col_wdata[r]),
      .raddr_i (wcol_raddr[r]),
      .rdata_o (wcol_rdata[r])
    );

    multi_read_ram #(
      .NUM_PORTS (NUM_RD)
    ) u_rd_col (
      .clk_w   (clk_w),
      .we_i    (col_we[r]),
      .waddr_i (col_waddr[r]),
      .wdata_i (col_wdata[r]),
      .raddr_i (rd_addr),
      .rdata_o (rcol_rdata[r])
    );
  end

endmodule

// File: source/xor_read_decoder.sv
/*
  read side of the XOR multi-port RAM
  XOR of one read port across all rows, forwarding of the write that commits
  at the read edge, and the one-cycle read valid register
*/
module xor_read_decoder import mpram_pkg::*; #(
  parameter int NUM_WR = 3,
  parameter int NUM_RD = 2
) (
  input  logic                           clk_w,
  input  logic                           a_rst_n,
  input  logic    [NUM_RD-1:0]           rd_fire_i,
  input  rd_req_t [NUM_RD-1:0]           rd_req_i,
  input  word_t   [NUM_WR-1:0][NUM_RD-1:0] col_rdata_i,
  input  logic    [NUM_WR-1:0]           pend_valid_i,
  input  addr_t   [NUM_WR-1:0]           pend_addr_i,
  input  word_t   [NUM_WR-1:0]           pend_data_i,
  output word_t   [NUM_RD-1:0]           rd_data_o,
  output logic    [NUM_RD-1:0]           rd_data_valid_o
);

  logic  [NUM_RD-1:0][NUM_WR-1:0] match;
  logic  [NUM_RD-1:0]             fwd_hit_q;
  word_t [NUM_RD-1:0]             fwd_data_q;
  word_t [NUM_RD-1:0]             xor_word;

  // ==================================================
  // forwarding of the committing write
  // ==================================================

  // write ports never share an address, so one match at most
  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      for (int w = 0; w < NUM_WR; w++) begin
        match[p][w] = pend_valid_i[w] && (pend_addr_i[w] == rd_req_i[p].addr);
      end
    end
  end

  always_ff @(posedge clk_w) begin
    if (!a_rst_n) begin
      fwd_hit_q       <= '0;
      rd_data_valid_o <= '0;
    end else begin
      rd_data_valid_o <= rd_fire_i;
      for (int p = 0; p < NUM_RD; p++) begin
        fwd_hit_q[p] <= |match[p];
      end
    end
  end

  always_ff @(posedge clk_w) begin
    for (int p = 0; p < NUM_RD; p++) begin
      for (int w = 0; w < NUM_WR; w++) begin
        if (match[p][w]) begin
          fwd_data_q[p] <= pend_data_i[w];
        end
      end
    end
  end

  // ==================================================
  // row XOR and output select
  // ==================================================

  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      xor_word[p] = '0;
      for (int w = 0; w < NUM_WR; w++) begin
        xor_word[p] ^= col_rdata_i[w][p];
      end
      rd_data_o[p] = fwd_hit_q[p] ? fwd_data_q[p] : xor_word[p];
    end
  end

endmodule

// File: source/xor_write_encoder.sv
/*
  write side of the XOR multi-port RAM
  pipeline register of accepted writes, XOR encoding against the other rows,
  bypass of same-edge column updates and the post-reset clearing sweep
*/
module xor_write_encoder import mpram_pkg::*; #(
  parameter int NUM_WR = 3
) (
  input  logic                             clk_w,
  input  logic                             a_rst_n,
  input  logic    [NUM_WR-1:0]             wr_fire_i,
  input  wr_req_t [NUM_WR-1:0]             wr_req_i,
  input  word_t   [NUM_WR-1:0][NUM_WR-2:0] col_rdata_i,
  output addr_t   [NUM_WR-1:0][NUM_WR-2:0] col_raddr_o,
  output logic    [NUM_WR-1:0]             col_we_o,
  output addr_t   [NUM_WR-1:0]             col_waddr_o,
  output word_t   [NUM_WR-1:0]             col_wdata_o,
  output logic    [NUM_WR-1:0]             pend_valid_o,
  output addr_t   [NUM_WR-1:0]             pend_addr_o,
  output word_t   [NUM_WR-1:0]             pend_data_o,
  output logic                             init_done_o
);

  typedef enum logic {
    ST_SWEEP,
    ST_RUN
  } state_e;

  state_e state_q;
  addr_t  sweep_addr_q;
  logic   sweep;

  // old words of the other rows, one slot per foreign write port
  logic  [NUM_WR-1:0][NUM_WR-2:0] byp_hit_q;
  word_t [NUM_WR-1:0][NUM_WR-2:0] byp_data_q;
  word_t [NUM_WR-1:0][NUM_WR-2:0] old_word;
  word_t [NUM_WR-1:0]             enc_data;

  // write port served by a slot of a row, the row's own port is skipped
  function automatic int slot_port(int row, int slot);
    return (slot < row) ? slot : slot + 1;
  endfunction

  // ==================================================
  // init sweep FSM
  // ==================================================

  always_ff @(posedge clk_w) begin
    if (!a_rst_n) begin
      state_q      <= ST_SWEEP;
      sweep_addr_q <= '0;
    end else begin
      case (state_q)
        ST_SWEEP: begin
          sweep_addr_q <= sweep_addr_q + 1'b1;
          if (sweep_addr_q == addr_t'(DEPTH - 1)) begin
            state_q <= ST_RUN;
          end
        end
        ST_RUN: begin
          state_q <= ST_RUN;
        end
        default: begin
          state_q <= ST_SWEEP;
        end
      endcase
    end
  end

  assign sweep       = (state_q == ST_SWEEP);
  assign init_done_o = (state_q == ST_RUN);

  // ==================================================
  // write pipeline register
  // ==================================================

  always_ff @(posedge clk_w) begin
    if (!a_rst_n) begin
      pend_valid_o <= '0;
    end else begin
      pend_valid_o <= wr_fire_i;
    end
  end

  always_ff @(posedge clk_w) begin
    for (int k = 0; k < NUM_WR; k++) begin
      pend_addr_o[k] <= wr_req_i[k].addr;
      pend_data_o[k] <= wr_req_i[k].data;
    end
  end

  // ==================================================
  // old word fetch and bypass
  // ==================================================

  // raw incoming addresses look up the other rows at the accept edge
  always_comb begin
    for (int i = 0; i < NUM_WR; i++) begin
      for (int j = 0; j < NUM_WR - 1; j++) begin
        col_raddr_o[i][j] = wr_req_i[slot_port(i, j)].addr;
      end
    end
  end

  // a row written at the fetch edge returns a stale word, keep the new one
  always_ff @(posedge clk_w) begin
    if (!a_rst_n) begin
      byp_hit_q <= '0;
    end else begin
      for (int i = 0; i < NUM_WR; i++) begin
        for (int j = 0; j < NUM_WR - 1; j++) begin
          byp_hit_q[i][j] <= col_we_o[i] && (col_waddr_o[i] == col_raddr_o[i][j]);
        end
      end
    end
  end

  always_ff @(posedge clk_w) begin
    for (int i = 0; i < NUM_WR; i++) begin
      for (int j = 0; j < NUM_WR - 1; j++) begin
        byp_data_q[i][j] <= col_wdata_o[i];
      end
    end
  end

  // ==================================================
  // XOR encoding and column write side
  // ==================================================

  always_comb begin
    enc_data = pend_data_o;
    for (int i = 0; i < NUM_WR; i++) begin
      for (int j = 0; j < NUM_WR - 1; j++) begin
        old_word[i][j] = byp_hit_q[i][j] ? byp_data_q[i][j] : col_rdata_i[i][j];
        enc_data[slot_port(i, j)] ^= old_word[i][j];
      end
    end
  end

  // sweep forces zero into every row
  always_comb begin
    for (int i = 0; i < NUM_WR; i++) begin
      col_we_o[i]    = sweep | pend_valid_o[i];
      col_waddr_o[i] = sweep ? sweep_addr_q : pend_addr_o[i];
      col_wdata_o[i] = sweep ? '0 : enc_data[i];
    end
  end

endmodule

// File: source/multi_read_ram.sv
/*
  memory column with one write port and NUM_PORTS registered read ports
  same-edge read of a written address returns the old word
*/
module multi_read_ram import mpram_pkg::*; #(
  parameter int NUM_PORTS = 2
) (
  input  logic                  clk_w,
  input  logic                  we_i,
  input  addr_t                 waddr_i,
  input  word_t                 wdata_i,
  input  addr_t [NUM_PORTS-1:0] raddr_i,
  output word_t [NUM_PORTS-1:0] rdata_o
);

  // storage, contents only defined after the init sweep
  word_t mem [DEPTH];

  // ==================================================
  // write port
  // ==================================================

  always_ff @(posedge clk_w) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // ==================================================
  // read ports
  // ==================================================

  // nonblocking read sees the array before this edge's write
  always_ff @(posedge clk_w) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      rdata_o[p] <= mem[raddr_i[p]];
    end
  end

endmodule

// File: source/mpram_pkg.sv
/*
  shared geometry and types of the XOR multi-port RAM
  word and address vectors, write and read request structs
*/
package mpram_pkg;

  // ==================================================
  // memory geometry
  // ==================================================

  // width of one stored word
  localparam int DATA_W = 32;

  // number of words per column
  localparam int DEPTH  = 64;

  localparam int ADDR_W = $clog2(DEPTH);

  // ==================================================
  // vector and request types
  // ==================================================

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // one write request, address plus plain data
  typedef struct packed {
    addr_t addr;
    word_t data;
  } wr_req_t;

  // one read request
  typedef struct packed {
    addr_t addr;
  } rd_req_t;

endpackage
